// ==== tb.f ====
+incdir+include
verilog/dcache_pkg.sv
verilog/dcache_req_if.sv
verilog/dcache_request_stage.sv
verilog/dcache_way_array.sv
verilog/dcache_replace.sv
verilog/dcache_lookup.sv
verilog/dcache_miss_ctrl.sv
verilog/dcache_top.sv
test/dcache_tb.sv

// ==== include/dcache_tb_model.svh ====
`ifndef DCACHE_TB_MODEL_SVH
`define DCACHE_TB_MODEL_SVH

// bus side memory and expected contents, keyed by line address
line_t bus_mem [logic [ADDR_W-1:0]];
line_t ref_mem [logic [ADDR_W-1:0]];

// shadow of tags, lru and dirty bits per set
tag_t shadow_tag [SETS][WAYS];
logic shadow_valid [SETS][WAYS] = '{default: 1'b0};
logic shadow_dirty [SETS][WAYS] = '{default: 1'b0};
logic shadow_lru [SETS] = '{default: 1'b0};

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
endfunction

function automatic logic [ADDR_W-1:0] line_addr(input logic [ADDR_W-1:0] addr);
    return {addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
endfunction

// seeded by 70 and the line address, so both memories start equal
function automatic line_t init_line(input logic [ADDR_W-1:0] addr);
    line_t l;
    logic [31:0] s;
    s = 32'd70 ^ line_addr(addr);
    for (int w = 0; w < WORDS_PER_LINE; w++) begin
        s = xorshift32(s);
        l.words[w] = s;
    end
    return l;
endfunction

function automatic line_t model_line(ref line_t mem [logic [ADDR_W-1:0]],
                                     input logic [ADDR_W-1:0] addr);
    if (!mem.exists(line_addr(addr))) begin
        mem[line_addr(addr)] = init_line(addr);
    end
    return mem[line_addr(addr)];
endfunction

function automatic void ref_write(input logic [ADDR_W-1:0] addr, input strb_t strb,
                                  input word_t data);
    line_t l;
    word_sel_t w;
    l = model_line(ref_mem, addr);
    w = addr[OFFSET_W-1 -: WORD_SEL_W];
    for (int b = 0; b < 4; b++) begin
        if (strb[b]) begin
            l.words[w][8*b +: 8] = data[8*b +: 8];
        end
    end
    ref_mem[line_addr(addr)] = l;
endfunction

function automatic word_t ref_read(input logic [ADDR_W-1:0] addr);
    line_t l;
    l = model_line(ref_mem, addr);
    return l.words[addr[OFFSET_W-1 -: WORD_SEL_W]];
endfunction

// 1 on a miss; victim_dirty and victim_addr predict the write-back
function automatic logic shadow_access(input logic [ADDR_W-1:0] addr, input logic write,
                                       output logic victim_dirty,
                                       output logic [ADDR_W-1:0] victim_addr);
    index_t idx;
    tag_t tag;
    logic way;
    idx = addr[OFFSET_W +: INDEX_W];
    tag = addr[ADDR_W-1 -: TAG_W];
    victim_dirty = 1'b0;
    victim_addr = '0;
    for (int w = 0; w < WAYS; w++) begin
        if (shadow_valid[idx][w] && shadow_tag[idx][w] == tag) begin
            shadow_lru[idx] = !w[0];
            shadow_dirty[idx][w] = shadow_dirty[idx][w] | write;
            return 1'b0;
        end
    end
    way = shadow_lru[idx];
    victim_dirty = shadow_valid[idx][way] && shadow_dirty[idx][way];
    victim_addr = {shadow_tag[idx][way], idx, {OFFSET_W{1'b0}}};
    shadow_valid[idx][way] = 1'b1;
    shadow_tag[idx][way] = tag;
    shadow_dirty[idx][way] = write;
    shadow_lru[idx] = !way;
    return 1'b1;
endfunction

`endif

// ==== test/dcache_tb.sv ====
`timescale 1ns/1ps

module dcache_tb;
    import dcache_pkg::*;

    `include "dcache_tb_model.svh"

    localparam int TIMEOUT = 200;

    // one accepted request and what the models predict for it
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic write;
        word_t exp;
        logic miss;
        logic vdirty;
        logic [ADDR_W-1:0] vaddr;
        line_t vline;
    } entry_t;

    logic clk;
    logic rst;
    logic rvalid_i;
    logic wvalid_i;
    logic [ADDR_W-1:0] paddr_i;
    strb_t wsel_i;
    word_t wdata_i;
    word_t rdata_o;
    logic data_ok_o;
    logic stall_o;
    logic rd_req_o;
    logic [ADDR_W-1:0] rd_addr_o;
    logic ret_valid_i;
    logic [WORDS_PER_LINE*32-1:0] ret_data_i;
    logic wr_req_o;
    logic [ADDR_W-1:0] wr_addr_o;
    logic [WORDS_PER_LINE*32-1:0] wr_data_o;
    logic wr_valid_i;

    logic [31:0] rng = 32'd70;
    string test_name = "reset";
    entry_t inflight [$];
    entry_t s2;
    logic s2_valid = 1'b0;

    dcache_top i_dcache_top (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    function automatic logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic logic [ADDR_W-1:0] mk_addr(input tag_t tag, input index_t idx,
                                                 input word_sel_t w);
        return {tag, idx, w, 2'b00};
    endfunction

    task automatic fail_stop(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_word(input string what, input word_t exp, input word_t act);
        if (exp !== act) begin
            fail_stop($sformatf("ERROR %s %s expected %h actual %h", test_name, what, exp, act));
        end
    endtask

    task automatic check_line(input string what, input line_t exp, input line_t act);
        if (exp !== act) begin
            fail_stop($sformatf("ERROR %s %s expected %h actual %h", test_name, what, exp, act));
        end
    endtask

    task automatic check_addr(input string what, input logic [ADDR_W-1:0] exp,
                              input logic [ADDR_W-1:0] act);
        if (exp !== act) begin
            fail_stop($sformatf("ERROR %s %s expected %h actual %h", test_name, what, exp, act));
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (exp !== act) begin
            fail_stop($sformatf("ERROR %s %s expected %b actual %b", test_name, what, exp, act));
        end
    endtask

    ////////////////////////////////////////
    // memory responder
    ////////////////////////////////////////

    initial begin
        int delay;
        line_t ln;
        ret_valid_i = 1'b0;
        ret_data_i = '0;
        wr_valid_i = 1'b0;
        forever begin
            @(negedge clk);
            ret_valid_i = 1'b0;
            wr_valid_i = 1'b0;
            if (wr_req_o === 1'b1) begin
                delay = next_rand() % 4;
                repeat (delay) @(negedge clk);
                ln.beat = wr_data_o;
                bus_mem[wr_addr_o] = ln;
                wr_valid_i = 1'b1;
            end else if (rd_req_o === 1'b1) begin
                delay = next_rand() % 4;
                repeat (delay) @(negedge clk);
                ln = model_line(bus_mem, rd_addr_o);
                ret_data_i = ln.beat;
                ret_valid_i = 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    // present one request and hold it until the cache takes it
    task automatic issue(input logic [ADDR_W-1:0] addr, input logic write, input strb_t strb,
                         input word_t data);
        entry_t e;
        logic vd;
        logic [ADDR_W-1:0] va;
        int waited;
        @(negedge clk);
        rvalid_i = !write;
        wvalid_i = write;
        paddr_i = addr;
        wsel_i = strb;
        wdata_i = data;
        #5;
        waited = 0;
        while (stall_o) begin
            waited++;
            if (waited > TIMEOUT) begin
                fail_stop("request was never accepted, stall_o stayed high");
            end
            @(negedge clk);
            #5;
        end
        e.addr = addr;
        e.write = write;
        e.miss = shadow_access(addr, write, vd, va);
        e.vdirty = e.miss && vd;
        e.vaddr = va;
        e.vline = e.vdirty ? model_line(ref_mem, va) : '0;
        e.exp = '0;
        if (write) begin
            ref_write(addr, strb, data);
        end else begin
            e.exp = ref_read(addr);
        end
        inflight.push_back(e);
    endtask

    task automatic idle();
        @(negedge clk);
        rvalid_i = 1'b0;
        wvalid_i = 1'b0;
        #5;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        idle();
        while (inflight.size() != 0 || s2_valid) begin
            waited++;
            if (waited > TIMEOUT) begin
                fail_stop("outstanding requests did not complete in time");
            end
            idle();
        end
    endtask

    initial begin
        logic [31:0] r;
        logic [ADDR_W-1:0] a;
        logic [ADDR_W-1:0] touched [$];
        rst = 1'b0;
        rvalid_i = 1'b0;
        wvalid_i = 1'b0;
        paddr_i = '0;
        wsel_i = '0;
        wdata_i = '0;
        repeat (16) @(negedge clk);
        rst = 1'b1;
        repeat (4) idle();

        test_name = "first_read";
        issue(mk_addr(20'h1, 8'd3, 2'd2), 1'b0, '0, '0);
        test_name = "repeat_read";
        issue(mk_addr(20'h1, 8'd3, 2'd0), 1'b0, '0, '0);
        issue(mk_addr(20'h1, 8'd3, 2'd2), 1'b0, '0, '0);

        test_name = "partial_write";
        issue(mk_addr(20'h1, 8'd3, 2'd1), 1'b1, 4'b0101, 32'hdeadbeef);
        issue(mk_addr(20'h1, 8'd3, 2'd1), 1'b0, '0, '0);
        issue(mk_addr(20'h2, 8'd5, 2'd3), 1'b1, 4'b1000, 32'h11223344);
        issue(mk_addr(20'h2, 8'd5, 2'd3), 1'b1, 4'b0110, 32'hcafef00d);
        issue(mk_addr(20'h2, 8'd5, 2'd0), 1'b1, 4'b1111, 32'h0badc0de);
        idle();
        issue(mk_addr(20'h2, 8'd5, 2'd3), 1'b0, '0, '0);
        issue(mk_addr(20'h2, 8'd5, 2'd0), 1'b0, '0, '0);

        // A, B, A, then C evicts B
        test_name = "lru";
        issue(mk_addr(20'h10, 8'd20, 2'd0), 1'b0, '0, '0);
        issue(mk_addr(20'h11, 8'd20, 2'd1), 1'b0, '0, '0);
        issue(mk_addr(20'h10, 8'd20, 2'd2), 1'b0, '0, '0);
        issue(mk_addr(20'h12, 8'd20, 2'd3), 1'b0, '0, '0);
        issue(mk_addr(20'h10, 8'd20, 2'd1), 1'b0, '0, '0);
        issue(mk_addr(20'h11, 8'd20, 2'd0), 1'b0, '0, '0);

        test_name = "dirty_evict";
        issue(mk_addr(20'h20, 8'd40, 2'd1), 1'b1, 4'b1111, 32'h5555aaaa);
        issue(mk_addr(20'h21, 8'd40, 2'd0), 1'b0, '0, '0);
        issue(mk_addr(20'h22, 8'd40, 2'd0), 1'b0, '0, '0);
        issue(mk_addr(20'h23, 8'd40, 2'd2), 1'b0, '0, '0);
        issue(mk_addr(20'h20, 8'd40, 2'd1), 1'b0, '0, '0);

        test_name = "random";
        for (int i = 0; i < 200; i++) begin
            r = next_rand();
            a = mk_addr(tag_t'(r[2:0] % 5), index_t'(60 + r[4:3]), r[6:5]);
            if (r[7]) begin
                issue(a, 1'b1, r[11:8], next_rand());
                touched.push_back(a);
            end else begin
                issue(a, 1'b0, '0, '0);
            end
        end

        test_name = "readback";
        foreach (touched[k]) begin
            issue(touched[k], 1'b0, '0, '0);
        end
        drain();

        $display("Simulation passed");
        $finish;
    end

    ////////////////////////////////////////
    // compare
    ////////////////////////////////////////

    initial begin
        int s2_cycles;
        logic seen_wr;
        line_t wb_line;
        s2_cycles = 0;
        seen_wr = 1'b0;
        forever begin
            @(negedge clk);
            #10;
            if (rst) begin
                if (s2_valid) begin
                    if (s2_cycles == 0) begin
                        check_flag("miss", s2.miss, stall_o);
                    end
                    if (wr_req_o) begin
                        if (!s2.vdirty) begin
                            fail_stop("write-back issued for a clean or absent victim");
                        end
                        wb_line.beat = wr_data_o;
                        check_addr("write-back address", s2.vaddr, wr_addr_o);
                        check_line("write-back data", s2.vline, wb_line);
                        seen_wr = 1'b1;
                    end
                    if (rd_req_o) begin
                        if (!s2.miss) begin
                            fail_stop("refill requested for a request that should hit");
                        end
                        if (s2.vdirty && !seen_wr) begin
                            fail_stop("refill requested before the dirty victim was written back");
                        end
                        check_addr("refill address", line_addr(s2.addr), rd_addr_o);
                    end
                    if (stall_o) begin
                        s2_cycles++;
                        if (s2_cycles > TIMEOUT) begin
                            fail_stop("miss was never served, stall_o stayed high");
                        end
                    end else begin
                        if (s2.vdirty && !seen_wr) begin
                            fail_stop("dirty victim was evicted without a write-back");
                        end
                        check_flag("data_ok", !s2.write, data_ok_o);
                        if (!s2.write) begin
                            check_word("read data", s2.exp, rdata_o);
                        end
                        s2_valid = 1'b0;
                    end
                end else begin
                    check_flag("idle stall", 1'b0, stall_o);
                    check_flag("idle data_ok", 1'b0, data_ok_o);
                    check_flag("idle rd_req", 1'b0, rd_req_o);
                    check_flag("idle wr_req", 1'b0, wr_req_o);
                end
                // request taken at the coming edge moves into stage 2
                if (!stall_o && (rvalid_i || wvalid_i)) begin
                    if (inflight.size() == 0) begin
                        fail_stop("cache took a request that the stimulus did not record");
                    end
                    s2 = inflight.pop_front();
                    s2_valid = 1'b1;
                    s2_cycles = 0;
                    seen_wr = 1'b0;
                end
            end
        end
    end

endmodule

// ==== verilog/dcache_lookup.sv ====
`timescale 1ns/1ps

module dcache_lookup (
    dcache_req_if.consumer req,
    input  logic way0_valid_i,
    input  dcache_pkg::tag_t way0_tag_i,
    input  dcache_pkg::line_t way0_line_i,
    input  logic way1_valid_i,
    input  dcache_pkg::tag_t way1_tag_i,
    input  dcache_pkg::line_t way1_line_i,
    input  logic victim_way_i,
    input  logic fill_i,
    input  dcache_pkg::line_t ret_data_i,
    output logic hit_o,
    output logic hit_way_o,
    output logic miss_o,
    output dcache_pkg::word_t rdata_o,
    output logic data_ok_o,
    output logic [dcache_pkg::WAYS-1:0] we_way_o,
    output dcache_pkg::line_t write_line_o
);
    import dcache_pkg::*;

    logic hit0;
    logic hit1;
    line_t hit_line;
    line_t base_line;
    line_t merged_line;
    word_t strb_mask;

    ////////////////////////////////////////
    // tag compare
    ////////////////////////////////////////

    assign hit0 = way0_valid_i && (way0_tag_i == req.tag);
    assign hit1 = way1_valid_i && (way1_tag_i == req.tag);

    assign hit_o = req.valid && (hit0 || hit1);
    assign miss_o = req.valid && !(hit0 || hit1);
    assign hit_way_o = hit1;

    assign hit_line = hit1 ? way1_line_i : way0_line_i;

    // the return beat replaces the array line during a fill
    assign base_line = fill_i ? ret_data_i : hit_line;

    ////////////////////////////////////////
    // write merge
    ////////////////////////////////////////

    always_comb begin
        for (int b = 0; b < 4; b++) begin
            strb_mask[8*b +: 8] = {8{req.wstrb[b]}};
        end
    end

    always_comb begin
        merged_line = base_line;
        if (req.write) begin
            merged_line.words[req.word] = (req.wdata & strb_mask)
                                        | (base_line.words[req.word] & ~strb_mask);
        end
    end

    assign write_line_o = merged_line;

    // victim way on a fill, hit way on a write hit
    always_comb begin
        we_way_o = '0;
        if (fill_i) begin
            we_way_o[victim_way_i] = 1'b1;
        end else if (hit_o && req.write) begin
            we_way_o[hit_way_o] = 1'b1;
        end
    end

    ////////////////////////////////////////
    // read return
    ////////////////////////////////////////

    assign rdata_o = base_line.words[req.word];
    assign data_ok_o = !req.write && (hit_o || fill_i);

endmodule

// ==== verilog/dcache_miss_ctrl.sv ====
`timescale 1ns/1ps

module dcache_miss_ctrl (
    input  logic clk,
    input  logic rst,
    dcache_req_if.consumer req,
    input  logic miss_i,
    input  logic victim_dirty_i,
    input  dcache_pkg::tag_t victim_tag_i,
    input  dcache_pkg::line_t victim_line_i,
    input  logic ret_valid_i,
    input  logic wr_valid_i,
    output logic stall_o,
    output logic fill_o,
    output logic rd_req_o,
    output logic [dcache_pkg::ADDR_W-1:0] rd_addr_o,
    output logic wr_req_o,
    output logic [dcache_pkg::ADDR_W-1:0] wr_addr_o,
    output logic [dcache_pkg::WORDS_PER_LINE*32-1:0] wr_data_o
);
    import dcache_pkg::*;

    logic [1:0] state_q;

    ////////////////////////////////////////
    // miss fsm
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            state_q <= MISS_IDLE;
        end else begin
            case (state_q)
                MISS_IDLE: begin
                    // dirty victim goes out first
                    if (miss_i) begin
                        state_q <= victim_dirty_i ? MISS_WRITE_BACK : MISS_REFILL;
                    end
                end
                MISS_WRITE_BACK: begin
                    if (wr_valid_i) begin
                        state_q <= MISS_REFILL;
                    end
                end
                MISS_REFILL: begin
                    if (ret_valid_i) begin
                        state_q <= MISS_IDLE;
                    end
                end
                default: begin
                    state_q <= MISS_IDLE;
                end
            endcase
        end
    end

    // fill happens on the return beat
    assign fill_o = (state_q == MISS_REFILL) && ret_valid_i;

    // released in the fill cycle
    assign stall_o = miss_i && !fill_o;

    ////////////////////////////////////////
    // bus requests
    ////////////////////////////////////////

    assign wr_req_o = (state_q == MISS_WRITE_BACK);
    assign wr_addr_o = {victim_tag_i, req.index, {OFFSET_W{1'b0}}};
    assign wr_data_o = victim_line_i.beat;

    assign rd_req_o = (state_q == MISS_REFILL);
    assign rd_addr_o = {req.tag, req.index, {OFFSET_W{1'b0}}};

endmodule

// ==== verilog/dcache_pkg.sv ====
package dcache_pkg;

    ////////////////////////////////////////
    // cache geometry
    ////////////////////////////////////////

    localparam int ADDR_W = 32;
    localparam int TAG_W = 20;
    localparam int INDEX_W = 8;
    localparam int WORD_SEL_W = 2;
    // byte offset inside a line
    localparam int OFFSET_W = ADDR_W - TAG_W - INDEX_W;
    localparam int WORDS_PER_LINE = 4;
    localparam int SETS = 256;
    localparam int WAYS = 2;

    // miss fsm states
    localparam logic [1:0] MISS_IDLE = 2'd0;
    localparam logic [1:0] MISS_WRITE_BACK = 2'd1;
    localparam logic [1:0] MISS_REFILL = 2'd2;

    ////////////////////////////////////////
    // address fields and data
    ////////////////////////////////////////

    typedef logic [TAG_W-1:0] tag_t;
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [WORD_SEL_W-1:0] word_sel_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0] strb_t;

    // flat beat on the bus, word view for select and merge
    typedef union packed {
        logic [WORDS_PER_LINE*32-1:0] beat;
        word_t [WORDS_PER_LINE-1:0] words;
    } line_t;

endpackage

// ==== verilog/dcache_replace.sv ====
`timescale 1ns/1ps

module dcache_replace (
    input  logic clk,
    input  logic rst,
    dcache_req_if.consumer req,
    input  logic hit_way_i,
    input  logic hit_i,
    input  logic fill_i,
    output logic victim_way_o,
    output logic victim_dirty_o
);
    import dcache_pkg::*;

    // lru bit names the way to evict
    logic [SETS-1:0] lru_q;
    logic [WAYS-1:0][SETS-1:0] dirty_q;

    assign victim_way_o = lru_q[req.index];
    assign victim_dirty_o = dirty_q[victim_way_o][req.index];

    always_ff @(posedge clk) begin
        if (!rst) begin
            lru_q <= '0;
        end else if (hit_i) begin
            lru_q[req.index] <= ~hit_way_i;
        end else if (fill_i) begin
            lru_q[req.index] <= ~victim_way_o;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            dirty_q <= '0;
        end else if (hit_i && req.write) begin
            dirty_q[hit_way_i][req.index] <= 1'b1;
        end else if (fill_i) begin
            // clean on a read fill, dirty on a write fill
            dirty_q[victim_way_o][req.index] <= req.write;
        end
    end

endmodule

// ==== verilog/dcache_req_if.sv ====
`timescale 1ns/1ps

interface dcache_req_if;
    import dcache_pkg::*;

    // stage-2 request
    logic valid;
    logic write;
    tag_t tag;
    index_t index;
    word_sel_t word;
    strb_t wstrb;
    word_t wdata;

    modport stage (
        output valid,
        output write,
        output tag,
        output index,
        output word,
        output wstrb,
        output wdata
    );

    modport consumer (
        input valid,
        input write,
        input tag,
        input index,
        input word,
        input wstrb,
        input wdata
    );

endinterface

// ==== verilog/dcache_request_stage.sv ====
`timescale 1ns/1ps

module dcache_request_stage (
    input  logic clk,
    input  logic rst,
    input  logic rvalid_i,
    input  logic wvalid_i,
    input  logic [dcache_pkg::ADDR_W-1:0] paddr_i,
    input  dcache_pkg::strb_t wsel_i,
    input  dcache_pkg::word_t wdata_i,
    input  logic stall_i,
    output dcache_pkg::index_t read_index_o,
    dcache_req_if.stage req
);
    import dcache_pkg::*;

    tag_t in_tag;
    index_t in_index;
    word_sel_t in_word;

    // address split
    assign in_tag = paddr_i[ADDR_W-1 -: TAG_W];
    assign in_index = paddr_i[OFFSET_W +: INDEX_W];
    assign in_word = paddr_i[OFFSET_W-1 -: WORD_SEL_W];

    always_ff @(posedge clk) begin
        if (!rst) begin
            req.valid <= 1'b0;
            req.write <= 1'b0;
        end else if (!stall_i) begin
            req.valid <= rvalid_i | wvalid_i;
            req.write <= wvalid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            req.tag <= in_tag;
            req.index <= in_index;
            req.word <= in_word;
            req.wstrb <= wsel_i;
            req.wdata <= wdata_i;
        end
    end

    // keep the arrays on the stage-2 set during a miss
    assign read_index_o = stall_i ? req.index : in_index;

endmodule

// ==== verilog/dcache_top.sv ====
`timescale 1ns/1ps

module dcache_top (
    input  logic clk,
    input  logic rst,
    // cpu side
    input  logic rvalid_i,
    input  logic wvalid_i,
    input  logic [dcache_pkg::ADDR_W-1:0] paddr_i,
    input  dcache_pkg::strb_t wsel_i,
    input  dcache_pkg::word_t wdata_i,
    output dcache_pkg::word_t rdata_o,
    output logic data_ok_o,
    output logic stall_o,
    // read bus
    output logic rd_req_o,
    output logic [dcache_pkg::ADDR_W-1:0] rd_addr_o,
    input  logic ret_valid_i,
    input  logic [dcache_pkg::WORDS_PER_LINE*32-1:0] ret_data_i,
    // write bus
    output logic wr_req_o,
    output logic [dcache_pkg::ADDR_W-1:0] wr_addr_o,
    output logic [dcache_pkg::WORDS_PER_LINE*32-1:0] wr_data_o,
    input  logic wr_valid_i
);
    import dcache_pkg::*;

    dcache_req_if req_if ();

    index_t read_index;
    logic way0_valid;
    logic way1_valid;
    tag_t way0_tag;
    tag_t way1_tag;
    line_t way0_line;
    line_t way1_line;
    logic [WAYS-1:0] we_way;
    line_t write_line;
    line_t ret_line;
    logic hit;
    logic hit_way;
    logic miss;
    logic fill;
    logic victim_way;
    logic victim_dirty;
    tag_t victim_tag;
    line_t victim_line;

    assign ret_line.beat = ret_data_i;
    assign victim_tag = victim_way ? way1_tag : way0_tag;
    assign victim_line = victim_way ? way1_line : way0_line;

    ////////////////////////////////////////
    // stage 1
    ////////////////////////////////////////

    dcache_request_stage i_request_stage (
        .clk(clk), .rst(rst),
        .rvalid_i(rvalid_i), .wvalid_i(wvalid_i), .paddr_i(paddr_i),
        .wsel_i(wsel_i), .wdata_i(wdata_i), .stall_i(stall_o),
        .read_index_o(read_index), .req(req_if.stage)
    );

    dcache_way_array i_way0 (
        .clk(clk), .rst(rst), .read_index_i(read_index),
        .we_i(we_way[0]), .write_index_i(req_if.index), .write_tag_i(req_if.tag),
        .write_line_i(write_line),
        .valid_o(way0_valid), .tag_o(way0_tag), .line_o(way0_line)
    );

    dcache_way_array i_way1 (
        .clk(clk), .rst(rst), .read_index_i(read_index),
        .we_i(we_way[1]), .write_index_i(req_if.index), .write_tag_i(req_if.tag),
        .write_line_i(write_line),
        .valid_o(way1_valid), .tag_o(way1_tag), .line_o(way1_line)
    );

    ////////////////////////////////////////
    // stage 2
    ////////////////////////////////////////

    dcache_replace i_replace (
        .clk(clk), .rst(rst), .req(req_if.consumer),
        .hit_way_i(hit_way), .hit_i(hit), .fill_i(fill),
        .victim_way_o(victim_way), .victim_dirty_o(victim_dirty)
    );

    dcache_lookup i_lookup (
        .req(req_if.consumer),
        .way0_valid_i(way0_valid), .way0_tag_i(way0_tag), .way0_line_i(way0_line),
        .way1_valid_i(way1_valid), .way1_tag_i(way1_tag), .way1_line_i(way1_line),
        .victim_way_i(victim_way), .fill_i(fill), .ret_data_i(ret_line),
        .hit_o(hit), .hit_way_o(hit_way), .miss_o(miss),
        .rdata_o(rdata_o), .data_ok_o(data_ok_o),
        .we_way_o(we_way), .write_line_o(write_line)
    );

    dcache_miss_ctrl i_miss_ctrl (
        .clk(clk), .rst(rst), .req(req_if.consumer),
        .miss_i(miss), .victim_dirty_i(victim_dirty),
        .victim_tag_i(victim_tag), .victim_line_i(victim_line),
        .ret_valid_i(ret_valid_i), .wr_valid_i(wr_valid_i),
        .stall_o(stall_o), .fill_o(fill),
        .rd_req_o(rd_req_o), .rd_addr_o(rd_addr_o),
        .wr_req_o(wr_req_o), .wr_addr_o(wr_addr_o), .wr_data_o(wr_data_o)
    );

endmodule

// ==== verilog/dcache_way_array.sv ====
`timescale 1ns/1ps

module dcache_way_array (
    input  logic clk,
    input  logic rst,
    input  dcache_pkg::index_t read_index_i,
    input  logic we_i,
    input  dcache_pkg::index_t write_index_i,
    input  dcache_pkg::tag_t write_tag_i,
    input  dcache_pkg::line_t write_line_i,
    output logic valid_o,
    output dcache_pkg::tag_t tag_o,
    output dcache_pkg::line_t line_o
);
    import dcache_pkg::*;

    logic [SETS-1:0] valid_q;
    tag_t tag_mem [SETS];
    line_t line_mem [SETS];
    logic bypass;

    // same index written and read in one cycle
    assign bypass = we_i && (write_index_i == read_index_i);

    ////////////////////////////////////////
    // storage
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            valid_q <= '0;
        end else if (we_i) begin
            valid_q[write_index_i] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (we_i) begin
            tag_mem[write_index_i] <= write_tag_i;
            line_mem[write_index_i] <= write_line_i;
        end
    end

    ////////////////////////////////////////
    // registered read, write-first
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= bypass | valid_q[read_index_i];
        end
    end

    always_ff @(posedge clk) begin
        if (bypass) begin
            tag_o <= write_tag_i;
            line_o <= write_line_i;
        end else begin
            tag_o <= tag_mem[read_index_i];
            line_o <= line_mem[read_index_i];
        end
    end

endmodule
